// File: hdl/data_ram.sv
`include "soc_settings.svh"

module data_ram (
    input  logic        clkConstrained,
    input  logic        ram_we,
    input  logic [7:0]  ram_addr,
    input  logic [31:0] ram_wdata,
    output logic [31:0] ram_rdata
);

    // word storage, contents undefined until written
    logic [31:0] mem [0:`RAM_WORDS-1];

    always_ff @(posedge clkConstrained) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end
    end

    // registered read, returns the old word on a same-cycle write
    always_ff @(posedge clkConstrained) begin
        ram_rdata <= mem[ram_addr];
    end

endmodule

// File: hdl/mem_bus.sv
`include "soc_settings.svh"

module mem_bus import soc_pkg::*; (
    input  logic        clkConstrained,
    input  logic        rst_n,
    input  logic        req_valid,
    input  mem_op_e     req_op,
    input  logic [31:0] req_addr,
    input  logic [31:0] req_wdata,
    input  logic [31:0] ram_rdata,
    input  logic [63:0] cycle_count,
    input  logic [63:0] time_count,
    input  logic [63:0] time_cmp,
    input  logic        tx_busy,
    output logic        resp_valid,
    output logic [31:0] resp_rdata,
    output logic        ram_we,
    output logic [7:0]  ram_addr,
    output logic [31:0] ram_wdata,
    output logic        cmp_wr_lo,
    output logic        cmp_wr_hi,
    output logic [31:0] cmp_wdata,
    output logic        tx_start,
    output logic [7:0]  tx_byte,
    output logic [31:0] gp,
    output logic        exited
);

    logic [31:0] word_addr;
    logic        is_load;
    logic        is_store;
    mmio_sel_e   sel;
    mmio_sel_e   resp_sel_q;
    logic        resp_load_q;
    logic [31:0] reg_val;
    logic [31:0] reg_val_q;

    // byte lanes are not decoded
    assign word_addr = {req_addr[31:2], 2'b00};
    assign is_load   = req_valid && (req_op == OP_LOAD);
    assign is_store  = req_valid && (req_op == OP_STORE);

    always_comb begin
        if (word_addr < 32'(`RAM_WORDS * 4)) begin
            sel = SEL_RAM;
        end else begin
            case (word_addr)
                `MMIO_BASE + `OFS_UART_TX:   sel = SEL_UART_TX;
                `MMIO_BASE + `OFS_UART_STAT: sel = SEL_UART_STAT;
                `MMIO_BASE + `OFS_CYCLE_LO:  sel = SEL_CYCLE_LO;
                `MMIO_BASE + `OFS_TIME_LO:   sel = SEL_TIME_LO;
                `MMIO_BASE + `OFS_TIME_HI:   sel = SEL_TIME_HI;
                `MMIO_BASE + `OFS_CMP_LO:    sel = SEL_CMP_LO;
                `MMIO_BASE + `OFS_CMP_HI:    sel = SEL_CMP_HI;
                `MMIO_BASE + `OFS_GP:        sel = SEL_GP;
                `MMIO_BASE + `OFS_EXIT:      sel = SEL_EXIT;
                default:                     sel = SEL_NONE;
            endcase
        end
    end

    // write strobes to the blocks
    assign ram_we    = is_store && (sel == SEL_RAM);
    assign ram_addr  = req_addr[9:2];
    assign ram_wdata = req_wdata;
    assign cmp_wr_lo = is_store && (sel == SEL_CMP_LO);
    assign cmp_wr_hi = is_store && (sel == SEL_CMP_HI);
    assign cmp_wdata = req_wdata;
    assign tx_start  = is_store && (sel == SEL_UART_TX);
    assign tx_byte   = req_wdata[7:0];

    // register value seen at the request edge
    always_comb begin
        case (sel)
            SEL_UART_STAT: reg_val = {31'd0, tx_busy};
            SEL_CYCLE_LO:  reg_val = cycle_count[31:0];
            SEL_TIME_LO:   reg_val = time_count[31:0];
            SEL_TIME_HI:   reg_val = time_count[63:32];
            SEL_CMP_LO:    reg_val = time_cmp[31:0];
            SEL_CMP_HI:    reg_val = time_cmp[63:32];
            SEL_GP:        reg_val = gp;
            SEL_EXIT:      reg_val = {31'd0, exited};
            default:       reg_val = '0;
        endcase
    end

    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid  <= 1'b0;
            resp_load_q <= 1'b0;
        end else begin
            resp_valid  <= is_load || is_store;
            resp_load_q <= is_load;
        end
    end

    always_ff @(posedge clkConstrained) begin
        resp_sel_q <= sel;
        reg_val_q  <= reg_val;
    end

    // stores answer with zero
    assign resp_rdata = !resp_load_q ? '0 :
                        (resp_sel_q == SEL_RAM) ? ram_rdata : reg_val_q;

    // gp freezes once the exit latch is set
    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            gp     <= '0;
            exited <= 1'b0;
        end else begin
            if (is_store && (sel == SEL_GP) && !exited) begin
                gp <= req_wdata;
            end
            if (is_store && (sel == SEL_EXIT)) begin
                exited <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/soc_main.sv
module soc_main import soc_pkg::*; (
    input  logic        clkConstrained,
    input  logic        rst_n,
    input  logic        req_valid,
    input  mem_op_e     req_op,
    input  logic [31:0] req_addr,
    input  logic [31:0] req_wdata,
    output logic        resp_valid,
    output logic [31:0] resp_rdata,
    output logic        uart_tx,
    output logic        timer_irq,
    output logic [5:0]  led,
    output logic        exited
);

    logic        ram_we;
    logic [7:0]  ram_addr;
    logic [31:0] ram_wdata;
    logic [31:0] ram_rdata;
    logic        cmp_wr_lo;
    logic        cmp_wr_hi;
    logic [31:0] cmp_wdata;
    logic [63:0] cycle_count;
    logic [63:0] time_count;
    logic [63:0] time_cmp;
    logic        tx_start;
    logic [7:0]  tx_byte;
    logic        tx_busy;
    logic [31:0] gp;

    // board LEDs are active low
    assign led = ~gp[5:0];

    timer_unit timer_i (
        .clkConstrained (clkConstrained),
        .rst_n          (rst_n),
        .cmp_wr_lo      (cmp_wr_lo),
        .cmp_wr_hi      (cmp_wr_hi),
        .cmp_wdata      (cmp_wdata),
        .cycle_count    (cycle_count),
        .time_count     (time_count),
        .time_cmp       (time_cmp),
        .timer_irq      (timer_irq)
    );

    uart_tx_fsm uart_tx_i (
        .clkConstrained (clkConstrained),
        .rst_n          (rst_n),
        .tx_start       (tx_start),
        .tx_byte        (tx_byte),
        .tx             (uart_tx),
        .tx_busy        (tx_busy)
    );

    data_ram ram_i (
        .clkConstrained (clkConstrained),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .ram_rdata      (ram_rdata)
    );

    mem_bus bus_i (
        .clkConstrained (clkConstrained),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .ram_rdata      (ram_rdata),
        .cycle_count    (cycle_count),
        .time_count     (time_count),
        .time_cmp       (time_cmp),
        .tx_busy        (tx_busy),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .cmp_wr_lo      (cmp_wr_lo),
        .cmp_wr_hi      (cmp_wr_hi),
        .cmp_wdata      (cmp_wdata),
        .tx_start       (tx_start),
        .tx_byte        (tx_byte),
        .gp             (gp),
        .exited         (exited)
    );

endmodule

// File: hdl/soc_pkg.sv
package soc_pkg;

    // data port request opcode
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } mem_op_e;

    // decoded target of a data request
    typedef enum logic [3:0] {
        SEL_RAM       = 4'd0,
        SEL_UART_TX   = 4'd1,
        SEL_UART_STAT = 4'd2,
        SEL_CYCLE_LO  = 4'd3,
        SEL_TIME_LO   = 4'd4,
        SEL_TIME_HI   = 4'd5,
        SEL_CMP_LO    = 4'd6,
        SEL_CMP_HI    = 4'd7,
        SEL_GP        = 4'd8,
        SEL_EXIT      = 4'd9,
        // anything outside RAM and the device registers
        SEL_NONE      = 4'd15
    } mmio_sel_e;

    // serial transmitter states, one frame is start, 8 data, stop
    typedef enum logic [1:0] {
        UART_IDLE  = 2'd0,
        UART_START = 2'd1,
        UART_DATA  = 2'd2,
        UART_STOP  = 2'd3
    } uart_state_e;

endpackage

// File: hdl/timer_unit.sv
`include "soc_settings.svh"

module timer_unit (
    input  logic        clkConstrained,
    input  logic        rst_n,
    input  logic        cmp_wr_lo,
    input  logic        cmp_wr_hi,
    input  logic [31:0] cmp_wdata,
    output logic [63:0] cycle_count,
    output logic [63:0] time_count,
    output logic [63:0] time_cmp,
    output logic        timer_irq
);

    localparam int PRESCALE_W = $clog2(`FMAX_MHZ + 1);
    localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(`FMAX_MHZ - 1);

    logic [PRESCALE_W-1:0] prescale;
    logic                  us_tick;
    logic [63:0]           time_next;
    logic [63:0]           cmp_next;

    // one tick per microsecond
    assign us_tick   = (prescale == PRESCALE_LAST);
    assign time_next = us_tick ? time_count + 64'd1 : time_count;

    // compare register is written one half at a time
    always_comb begin
        cmp_next = time_cmp;
        if (cmp_wr_lo) begin
            cmp_next[31:0] = cmp_wdata;
        end
        if (cmp_wr_hi) begin
            cmp_next[63:32] = cmp_wdata;
        end
    end

    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 64'd1;
        end
    end

    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            prescale   <= '0;
            time_count <= '0;
        end else begin
            prescale   <= us_tick ? '0 : prescale + 1'b1;
            time_count <= time_next;
        end
    end

    // starts at all ones so the interrupt stays low after reset
    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            time_cmp <= '1;
        end else begin
            time_cmp <= cmp_next;
        end
    end

    // compare the next values so irq tracks the registered counter exactly
    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (time_next >= cmp_next);
        end
    end

endmodule

// File: hdl/uart_tx_fsm.sv
`include "soc_settings.svh"

module uart_tx_fsm import soc_pkg::*; (
    input  logic       clkConstrained,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx,
    output logic       tx_busy
);

    localparam int BAUD_W = $clog2(`UART_CLKS_PER_BIT + 1);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`UART_CLKS_PER_BIT - 1);

    uart_state_e       state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_idx;
    logic [7:0]        shift_q;
    logic              bit_done;

    // last cycle of the current bit period
    assign bit_done = (baud_cnt == BAUD_LAST);
    assign tx_busy  = (state != UART_IDLE);

    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            state    <= UART_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            shift_q  <= '0;
            tx       <= 1'b1;
        end else begin
            case (state)
                UART_IDLE: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    // start bit goes out on the same edge the byte is taken
                    if (tx_start) begin
                        shift_q <= tx_byte;
                        tx      <= 1'b0;
                        state   <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        tx       <= shift_q[0];
                        state    <= UART_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;
                            state <= UART_STOP;
                        end else begin
                            // lsb first
                            bit_idx <= bit_idx + 3'd1;
                            shift_q <= shift_q >> 1;
                            tx      <= shift_q[1];
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        state    <= UART_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    tx    <= 1'b1;
                    state <= UART_IDLE;
                end
            endcase
        end
    end

endmodule

// File: include/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// clock cycles per microsecond
`define FMAX_MHZ 27

// clock cycles per serial bit, kept short for simulation
`define UART_CLKS_PER_BIT 16

// data RAM depth in 32-bit words
`define RAM_WORDS 256

// device register region
`define MMIO_BASE (32'hF000_0000)

// register offsets from MMIO_BASE
`define OFS_UART_TX   (32'h00)
`define OFS_UART_STAT (32'h04)
`define OFS_CYCLE_LO  (32'h08)
`define OFS_TIME_LO   (32'h0C)
`define OFS_TIME_HI   (32'h10)
`define OFS_CMP_LO    (32'h14)
`define OFS_CMP_HI    (32'h18)
`define OFS_GP        (32'h1C)
`define OFS_EXIT      (32'h20)

`endif

// File: mini_soc.f
+incdir+include
hdl/soc_pkg.sv
hdl/timer_unit.sv
hdl/uart_tx_fsm.sv
hdl/data_ram.sv
hdl/mem_bus.sv
hdl/soc_main.sv
test/soc_main_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -f mini_soc.f --top-module soc_main_tb \
    -o soc_main_tb_sim > build.log 2>&1 \
    && ./obj_dir/soc_main_tb_sim > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"

grep -qx "Test passed" sim.log 2>/dev/null \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

// File: test/soc_main_tb.sv
`include "soc_settings.svh"

module soc_main_tb import soc_pkg::*; ();

    localparam int BIT_CLKS = `UART_CLKS_PER_BIT;
    localparam logic [31:0] BASE = `MMIO_BASE;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        logic        check;
    } table_entry_t;

    logic        clkConstrained = 1'b0;
    logic        rst_n;
    logic        req_valid;
    mem_op_e     req_op;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        uart_tx;
    logic        timer_irq;
    logic [5:0]  led;
    logic        exited;

    table_entry_t stim[$];
    logic [31:0]  posedge_count = '0;
    logic [31:0]  issue_edge;
    int           error_count = 0;
    int           errors_before = 0;
    int           test_count = 0;
    int           failed_tests = 0;

    soc_main dut_i (.*);

    always #4 clkConstrained = ~clkConstrained;

    // edge numbers give the elapsed cycles between two requests
    always @(posedge clkConstrained) begin
        posedge_count <= posedge_count + 32'd1;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0s: ok", name);
        end else begin
            failed_tests++;
            $display("test %0s: %0d errors", name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    // called on a falling edge and returns on the falling edge that shows the response
    task automatic issue_request(input mem_op_e op, input logic [31:0] addr,
                                 input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        req_valid  = 1'b1;
        req_op     = op;
        req_addr   = addr;
        req_wdata  = wdata;
        issue_edge = posedge_count;
        @(negedge clkConstrained);
        req_valid = 1'b0;
        req_op    = OP_NONE;
        for (waited = 0; waited < 20 && !resp_valid; waited++) begin
            @(negedge clkConstrained);
        end
        rdata = resp_rdata;
        if (!resp_valid) begin
            error_count++;
            $display("no response to the request at address 0x%h", addr);
        end else if (waited != 0) begin
            error_count++;
            $display("response to the request at address 0x%h came %0d cycles late",
                     addr, waited);
        end
    endtask

    task automatic bus_store(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        issue_request(OP_STORE, addr, wdata, rdata);
        check_value("resp_rdata on store", rdata, 32'd0);
    endtask

    task automatic bus_load(input logic [31:0] addr, output logic [31:0] rdata);
        issue_request(OP_LOAD, addr, 32'd0, rdata);
    endtask

    task automatic add_entry(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [31:0] expected, input logic check);
        stim.push_back(table_entry_t'{op, addr, wdata, expected, check});
    endtask

    task automatic build_table();
        logic [31:0] w0, w1, w2;
        w0 = $urandom;
        w1 = $urandom;
        w2 = $urandom;
        add_entry(OP_STORE, 32'h0000_0000, w0, 32'd0, 1'b0);
        add_entry(OP_STORE, 32'h0000_0010, w1, 32'd0, 1'b0);
        add_entry(OP_STORE, 32'h0000_03FC, w2, 32'd0, 1'b0);
        add_entry(OP_STORE, 32'h0000_0400, ~w0, 32'd0, 1'b0);
        add_entry(OP_LOAD, 32'h0000_0000, 32'd0, w0, 1'b1);
        add_entry(OP_LOAD, 32'h0000_0010, 32'd0, w1, 1'b1);
        add_entry(OP_LOAD, 32'h0000_03FC, 32'd0, w2, 1'b1);
        // byte offsets within a word alias to that word
        add_entry(OP_LOAD, 32'h0000_0013, 32'd0, w1, 1'b1);
        add_entry(OP_LOAD, 32'h0000_03FE, 32'd0, w2, 1'b1);
        // nothing decoded here
        add_entry(OP_LOAD, 32'h0000_0400, 32'd0, 32'd0, 1'b1);
        add_entry(OP_LOAD, 32'h8000_0000, 32'd0, 32'd0, 1'b1);
        add_entry(OP_LOAD, BASE + 32'h100, 32'd0, 32'd0, 1'b1);
        // device registers still at their reset values
        add_entry(OP_LOAD, BASE + `OFS_CMP_LO, 32'd0, 32'hFFFF_FFFF, 1'b1);
        add_entry(OP_LOAD, BASE + `OFS_CMP_HI, 32'd0, 32'hFFFF_FFFF, 1'b1);
        add_entry(OP_LOAD, BASE + `OFS_UART_STAT, 32'd0, 32'd0, 1'b1);
        add_entry(OP_LOAD, BASE + `OFS_GP, 32'd0, 32'd0, 1'b1);
        add_entry(OP_LOAD, BASE + `OFS_EXIT, 32'd0, 32'd0, 1'b1);
    endtask

    // start bit is first seen half a cycle in so each sample lands mid bit
    task automatic receive_frame(output logic [7:0] data);
        int waited;
        data = '0;
        for (waited = 0; waited < 40 && uart_tx !== 1'b0; waited++) begin
            @(negedge clkConstrained);
        end
        if (uart_tx !== 1'b0) begin
            error_count++;
            $display("no start bit appeared on uart_tx");
        end else begin
            repeat (BIT_CLKS / 2 - 1) @(negedge clkConstrained);
            check_value("uart_tx start bit", 32'(uart_tx), 32'd0);
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge clkConstrained);
                data[i] = uart_tx;
            end
            repeat (BIT_CLKS) @(negedge clkConstrained);
            check_value("uart_tx stop bit", 32'(uart_tx), 32'd1);
        end
    endtask

    initial begin
        logic [31:0] seed_val, rdata, first, edge_a, delta, gp_val;
        logic [7:0]  tx_a, rx_byte;
        int          waited, low_seen;

        seed_val  = $urandom(96955);
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = OP_NONE;
        req_addr  = '0;
        req_wdata = '0;
        repeat (4) @(negedge clkConstrained);
        rst_n = 1'b1;
        @(negedge clkConstrained);
        check_value("uart_tx", 32'(uart_tx), 32'd1);
        check_value("resp_valid", 32'(resp_valid), 32'd0);
        check_value("timer_irq", 32'(timer_irq), 32'd0);
        check_value("led", {26'd0, led}, 32'h3F);
        check_value("exited", 32'(exited), 32'd0);
        report_test("reset state");

        build_table();
        foreach (stim[i]) begin
            if (stim[i].op == OP_STORE) begin
                bus_store(stim[i].addr, stim[i].wdata);
            end else begin
                bus_load(stim[i].addr, rdata);
                if (stim[i].check) begin
                    check_value("resp_rdata", rdata, stim[i].expected);
                end
            end
        end
        report_test("ram and register table");

        bus_load(BASE + `OFS_CYCLE_LO, first);
        edge_a = issue_edge;
        // the response is a single-cycle pulse
        @(negedge clkConstrained);
        check_value("resp_valid after response", 32'(resp_valid), 32'd0);
        repeat (36) @(negedge clkConstrained);
        bus_load(BASE + `OFS_CYCLE_LO, rdata);
        check_value("cycle_lo delta", rdata - first, issue_edge - edge_a);
        bus_load(BASE + `OFS_TIME_LO, first);
        edge_a = issue_edge;
        repeat (200) @(negedge clkConstrained);
        bus_load(BASE + `OFS_TIME_LO, rdata);
        delta = (issue_edge - edge_a) / `FMAX_MHZ;
        // prescaler phase may add one tick
        if (rdata - first != delta + 32'd1) begin
            check_value("time_lo delta", rdata - first, delta);
        end
        report_test("counters");

        check_value("timer_irq", 32'(timer_irq), 32'd0);
        bus_load(BASE + `OFS_TIME_LO, first);
        bus_store(BASE + `OFS_CMP_HI, 32'd0);
        bus_store(BASE + `OFS_CMP_LO, first + 32'd3);
        check_value("timer_irq before compare", 32'(timer_irq), 32'd0);
        for (waited = 0; waited < 10 * `FMAX_MHZ && !timer_irq; waited++) begin
            @(negedge clkConstrained);
        end
        if (!timer_irq) begin
            error_count++;
            $display("timer_irq did not rise after the compare value was reached");
        end
        bus_load(BASE + `OFS_CMP_LO, rdata);
        check_value("cmp_lo", rdata, first + 32'd3);
        bus_load(BASE + `OFS_CMP_HI, rdata);
        check_value("cmp_hi", rdata, 32'd0);
        report_test("timer interrupt");

        tx_a = 8'($urandom);
        fork
            receive_frame(rx_byte);
            begin
                bus_store(BASE + `OFS_UART_TX, {24'd0, tx_a});
                // dropped while the first frame is still going out
                bus_store(BASE + `OFS_UART_TX, {24'd0, ~tx_a});
                bus_load(BASE + `OFS_UART_STAT, rdata);
                check_value("uart_stat while busy", rdata, 32'd1);
            end
        join
        check_value("uart byte", {24'd0, rx_byte}, {24'd0, tx_a});
        rdata = 32'd1;
        for (waited = 0; waited < 4 * BIT_CLKS && rdata[0]; waited++) begin
            bus_load(BASE + `OFS_UART_STAT, rdata);
        end
        check_value("uart_stat after frame", rdata, 32'd0);
        low_seen = 0;
        repeat (12 * BIT_CLKS) begin
            @(negedge clkConstrained);
            if (!uart_tx) begin
                low_seen++;
            end
        end
        check_value("uart_tx low cycles after frame", 32'(low_seen), 32'd0);
        report_test("serial transmitter");

        gp_val = $urandom;
        bus_store(BASE + `OFS_GP, gp_val);
        check_value("led", {26'd0, led}, {26'd0, ~gp_val[5:0]});
        bus_load(BASE + `OFS_GP, rdata);
        check_value("gp", rdata, gp_val);
        bus_store(BASE + `OFS_EXIT, 32'd1);
        check_value("exited", 32'(exited), 32'd1);
        bus_store(BASE + `OFS_GP, ~gp_val);
        check_value("led after exit", {26'd0, led}, {26'd0, ~gp_val[5:0]});
        bus_load(BASE + `OFS_GP, rdata);
        check_value("gp after exit", rdata, gp_val);
        report_test("gp, leds and exit");

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
